// ==== sources.f ====
+incdir+verilog
verilog/id_pkg.sv
verilog/idu_1.sv
verilog/inst_queue.sv
verilog/dec_scoreboard.sv
verilog/id_ctrl_regs.sv
verilog/mips_decode_top.sv
dv/tb_clock.sv
dv/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the decode front end testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_top > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "Test OK" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== dv/tb_top.sv ====
`timescale 1ns/1ns

`include "id_settings.svh"

module tb_top
    import id_pkg::*;
();

    localparam int DEPTH      = `ID_QUEUE_DEPTH;
    localparam int N_FIRST    = 3;
    localparam int N_RANDOM   = 40;
    localparam int N_PUSHES   = N_FIRST + N_RANDOM + DEPTH + 3;
    localparam int MAX_CYCLES = 40 * N_PUSHES + 200;

    localparam logic [`ID_WB_AW-1:0] ADR_PUSH   = `ID_WB_AW'(`ID_ADR_PUSH);
    localparam logic [`ID_WB_AW-1:0] ADR_CTRL   = `ID_WB_AW'(`ID_ADR_CTRL);
    localparam logic [`ID_WB_AW-1:0] ADR_STATUS = `ID_WB_AW'(`ID_ADR_STATUS);
    localparam logic [`ID_WB_AW-1:0] ADR_COUNT  = `ID_WB_AW'(`ID_ADR_COUNT);

    logic       clk;
    logic       reset        = 1'b1;
    wb_req_t    wb_req       = '0;
    wb_rsp_t    wb_rsp;
    logic       issue_ready  = 1'b0;
    logic       retire_valid = 1'b0;
    logic [4:0] retire_reg   = 5'd0;
    logic       issue_valid;
    id_bundle_t issue_bundle;

    logic [31:0] model_q[$];          // accepted words not yet transferred
    logic [4:0]  pending[$];          // issued destinations waiting for retire
    logic [31:0] busy_q      = '0;
    logic [31:0] busy_before = '0;    // busy bits as seen by the last load
    logic        prev_valid  = 1'b0;
    logic        prev_ready  = 1'b0;
    id_bundle_t  held_bundle;
    logic [31:0] rd_data;
    int          n_checks    = 0;
    int          n_errors    = 0;
    int          err_base    = 0;
    int          n_transfers = 0;
    int          cycle_count = 0;

    funct_e fn_table [28] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_JR,
        FN_JALR, FN_SYSCALL, FN_BREAK, FN_MFHI, FN_MTHI, FN_MFLO, FN_MTLO, FN_MULT,
        FN_MULTU, FN_DIV, FN_DIVU, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR,
        FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
    op_code_e op_table [24] = '{OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_ADDI,
        OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LB, OP_LH,
        OP_LWL, OP_LW, OP_LBU, OP_LHU, OP_LWR, OP_SB, OP_SH, OP_SW};
    regimm_rt_e rt_table [4] = '{RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL};
    cop0_rs_e   c0_table [3] = '{C0_MFC0, C0_MTC0, C0_ERET};

    tb_clock #(.PERIOD_NS(4)) tb_clock_i (.clk(clk));

    mips_decode_top mips_decode_top_i (
        .clk          (clk),
        .reset        (reset),
        .wb_req       (wb_req),
        .issue_ready  (issue_ready),
        .retire_valid (retire_valid),
        .retire_reg   (retire_reg),
        .wb_rsp       (wb_rsp),
        .issue_valid  (issue_valid),
        .issue_bundle (issue_bundle)
    );

    task automatic check_val(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        n_checks++;
        assert (cond) else begin
            n_errors++;
            $display("ERROR t=%0t %s", $time, what);
        end
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d errors", name, n_errors - err_base);
        err_base = n_errors;
    endtask

    // expected decode, written out per instruction
    function automatic id_bundle_t model_decode(input logic [31:0] w);
        id_bundle_t b;
        logic [4:0] dst;
        logic       wr;
        b             = '0;
        dst           = 5'd0;
        wr            = 1'b0;
        b.inst        = w;
        b.op_code     = op_code_e'(w[31:26]);
        b.rs          = w[25:21];
        b.rt          = w[20:16];
        b.rd          = w[15:11];
        b.sa          = w[10:6];
        b.funct       = w[5:0];
        b.imme        = w[15:0];
        b.j_imme      = w[25:0];
        b.issue_class = CLS_ALU;
        case (b.op_code)
            OP_SPECIAL: begin
                case (funct_e'(w[5:0]))
                    FN_SLL, FN_SRL, FN_SRA: begin
                        {wr, dst} = {1'b1, b.rd};
                        b.reads_rt = 1'b1;
                    end
                    FN_SLLV, FN_SRLV, FN_SRAV, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND,
                    FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU: begin
                        {wr, dst} = {1'b1, b.rd};
                        {b.reads_rs, b.reads_rt} = 2'b11;
                    end
                    FN_JR, FN_JALR: begin
                        if (w[5:0] == FN_JALR)
                            {wr, dst} = {1'b1, b.rd};
                        {b.reads_rs, b.is_jr} = 2'b11;
                        b.issue_class = CLS_JUMP_REG;
                    end
                    FN_MFHI, FN_MFLO: begin
                        {wr, dst} = {1'b1, b.rd};
                        b.is_hilo = 1'b1;
                        b.issue_class = CLS_HILO;
                    end
                    FN_MTHI, FN_MTLO, FN_MULT, FN_MULTU, FN_DIV, FN_DIVU: begin
                        b.reads_rs = 1'b1;
                        b.reads_rt = !(w[5:0] inside {FN_MTHI, FN_MTLO});
                        b.is_hilo = 1'b1;
                        b.issue_class = CLS_HILO;
                    end
                    FN_SYSCALL, FN_BREAK:
                        b.issue_class = CLS_SYSTEM;
                    default: ;
                endcase
            end
            OP_REGIMM: begin
                if (b.rt == RT_BLTZAL || b.rt == RT_BGEZAL)
                    {wr, dst} = {1'b1, 5'd31};   // link
                {b.reads_rs, b.is_branch} = 2'b11;
                b.issue_class = CLS_BRANCH;
            end
            OP_J, OP_JAL: begin
                if (b.op_code == OP_JAL) begin
                    {wr, dst} = {1'b1, 5'd31};
                    b.is_branch = 1'b1;
                end
                b.is_j_imme = 1'b1;
                b.issue_class = CLS_JUMP;
            end
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
                b.reads_rs = 1'b1;
                b.reads_rt = b.op_code inside {OP_BEQ, OP_BNE};
                b.is_branch = 1'b1;
                b.issue_class = CLS_BRANCH;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                {wr, dst} = {1'b1, b.rt};
                b.reads_rs = (b.op_code != OP_LUI);
            end
            OP_LB, OP_LH, OP_LWL, OP_LW, OP_LBU, OP_LHU, OP_LWR, OP_SB, OP_SH, OP_SW: begin
                if (!(b.op_code inside {OP_SB, OP_SH, OP_SW}))
                    {wr, dst} = {1'b1, b.rt};
                b.reads_rs = 1'b1;
                b.reads_rt = b.op_code inside {OP_LWL, OP_LWR, OP_SB, OP_SH, OP_SW};
                b.is_ls = 1'b1;
                b.issue_class = CLS_LOAD_STORE;
            end
            OP_COP0: begin
                if (b.rs == C0_MFC0)
                    {wr, dst} = {1'b1, b.rt};
                b.reads_rt = (b.rs == C0_MTC0);
                b.issue_class = CLS_SYSTEM;
            end
            default: ;
        endcase
        b.w_reg_dst = dst;
        b.w_reg_ena = wr && (dst != 5'd0);
        return b;
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w = $urandom;
        w[25:21] = 5'($urandom % 8);   // few registers so hazards are common
        w[20:16] = 5'($urandom % 8);
        w[15:11] = 5'($urandom % 8);
        case ($urandom % 4)
            0: begin
                w[31:26] = OP_SPECIAL;
                w[5:0]   = fn_table[$urandom % 28];
            end
            1: begin
                w[31:26] = OP_REGIMM;
                w[20:16] = rt_table[$urandom % 4];
            end
            2: begin
                w[31:26] = OP_COP0;
                w[25:21] = c0_table[$urandom % 3];
                w[5:0]   = 6'h18;
            end
            default:
                w[31:26] = op_table[$urandom % 24];
        endcase
        return w;
    endfunction

    task automatic wb_write(input logic [`ID_WB_AW-1:0] adr, input logic [31:0] data);
        wb_req_t req;
        req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat_w: data};
        @(posedge clk);
        wb_req <= req;
        do @(posedge clk); while (!wb_rsp.ack);
        wb_req <= '0;
    endtask

    task automatic wb_read(input logic [`ID_WB_AW-1:0] adr, output logic [31:0] data);
        wb_req_t req;
        req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat_w: 32'd0};
        @(posedge clk);
        wb_req <= req;
        do @(posedge clk); while (!wb_rsp.ack);
        data = wb_rsp.dat_r;
        wb_req <= '0;
    endtask

    task automatic push_word(input logic [31:0] w, input logic stored);
        wb_write(ADR_PUSH, w);
        if (stored)
            model_q.push_back(w);
    endtask

    task automatic drain();
        while (model_q.size() != 0)
            @(posedge clk);
    endtask

    // issue port monitor, busy model and back end
    always @(posedge clk) begin
        if (!reset) begin
            if (prev_valid && !prev_ready) begin
                check_val("issue_valid", 128'(issue_valid), 128'(1));
                check_val("issue_bundle", 128'(issue_bundle), 128'(held_bundle));
            end
            if (issue_valid && (!prev_valid || prev_ready)) begin   // loaded last edge
                check_true(!(issue_bundle.reads_rs && busy_before[issue_bundle.rs])
                           && !(issue_bundle.reads_rt && busy_before[issue_bundle.rt])
                           && !(issue_bundle.w_reg_ena
                                && busy_before[issue_bundle.w_reg_dst]),
                           "bundle issued while a register it uses was still busy");
                if (issue_bundle.w_reg_ena && issue_bundle.w_reg_dst != 5'd0)
                    busy_q[issue_bundle.w_reg_dst] = 1'b1;
            end
            busy_before = busy_q;
            if (retire_valid)
                busy_q[retire_reg] = 1'b0;
            if (issue_valid && issue_ready) begin
                n_transfers++;
                if (model_q.size() == 0)
                    check_true(1'b0, "a word was issued that the queue never accepted");
                else
                    check_val("issue_bundle", 128'(issue_bundle),
                              128'(model_decode(model_q.pop_front())));
                if (issue_bundle.w_reg_ena)
                    pending.push_back(issue_bundle.w_reg_dst);
            end
            prev_valid  = issue_valid;
            prev_ready  = issue_ready;
            held_bundle = issue_bundle;
            if (pending.size() != 0 && ($urandom % 3) == 0) begin
                retire_valid <= 1'b1;
                retire_reg   <= pending.pop_front();
            end else begin
                retire_valid <= 1'b0;
            end
            issue_ready <= ($urandom % 4) != 0;
        end
    end

    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        rd_data = $urandom(71990);
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        wb_read(ADR_STATUS, rd_data);
        check_val("status", 128'(rd_data), 128'(0));
        wb_read(ADR_COUNT, rd_data);
        check_val("count", 128'(rd_data), 128'(0));
        wb_read(ADR_CTRL, rd_data);
        check_val("ctrl", 128'(rd_data), 128'(0));
        for (int i = 0; i < N_FIRST; i++)
            push_word(random_word(), 1'b1);
        repeat (20) begin
            @(posedge clk);
            check_val("issue_valid", 128'(issue_valid), 128'(0));
        end
        wb_read(ADR_STATUS, rd_data);
        check_val("status.level", 128'(rd_data[3:0]), 128'(N_FIRST));
        wb_read(ADR_PUSH, rd_data);
        check_val("push readback", 128'(rd_data), 128'(0));
        wb_write(ADR_CTRL, 32'd1);
        wb_read(ADR_CTRL, rd_data);
        check_val("ctrl", 128'(rd_data), 128'(1));
        drain();
        end_test("reset_enable");

        for (int i = 0; i < N_RANDOM; i++) begin
            while (model_q.size() >= DEPTH)   // keep the queue from overflowing
                @(posedge clk);
            push_word(random_word(), 1'b1);
        end
        drain();
        end_test("random_stream");

        wb_write(ADR_CTRL, 32'd0);
        for (int i = 0; i < DEPTH + 3; i++)
            push_word(random_word(), i < DEPTH);
        wb_read(ADR_STATUS, rd_data);
        check_val("status.level", 128'(rd_data[3:0]), 128'(DEPTH));
        check_val("status.overflow", 128'(rd_data[`ID_STAT_OVF_BIT]), 128'(1));
        wb_write(ADR_CTRL, 32'd3);   // enable and clear overflow
        wb_read(ADR_STATUS, rd_data);
        check_val("status.overflow", 128'(rd_data[`ID_STAT_OVF_BIT]), 128'(0));
        drain();
        wb_read(ADR_STATUS, rd_data);
        check_val("status.level", 128'(rd_data[3:0]), 128'(0));
        end_test("overflow");

        while (pending.size() != 0)
            @(posedge clk);
        wb_read(ADR_COUNT, rd_data);
        check_val("count", 128'(rd_data), 128'(n_transfers));
        wb_read(ADR_STATUS, rd_data);
        check_val("status.busy_any", 128'(rd_data[`ID_STAT_BUSY_BIT]), 128'(0));
        end_test("count");

        $display("checks %0d, errors %0d, transfers %0d", n_checks, n_errors, n_transfers);
        if (n_errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// ==== verilog/mips_decode_top.sv ====
`timescale 1ns/1ns

`include "id_settings.svh"

module mips_decode_top
    import id_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  wb_req_t    wb_req,
    input  logic       issue_ready,
    input  logic       retire_valid,
    input  logic [4:0] retire_reg,
    output wb_rsp_t    wb_rsp,
    output logic       issue_valid,
    output id_bundle_t issue_bundle
);

    localparam int LEVEL_W = $clog2(`ID_QUEUE_DEPTH + 1);

    logic               push_valid;
    logic [31:0]        push_data;
    logic               clear_overflow;
    logic               issue_enable;
    logic [LEVEL_W-1:0] level;
    logic               overflow;
    logic               head_valid;
    logic [31:0]        head_word;
    id_bundle_t         head_bundle;
    logic               pop;
    logic               issued_pulse;
    logic               busy_any;

    id_ctrl_regs #(.LEVEL_W(LEVEL_W)) id_ctrl_regs_i (
        .clk            (clk),
        .reset          (reset),
        .wb_req         (wb_req),
        .level          (level),
        .overflow       (overflow),
        .busy_any       (busy_any),
        .issued_pulse   (issued_pulse),
        .wb_rsp         (wb_rsp),
        .push_valid     (push_valid),
        .push_data      (push_data),
        .clear_overflow (clear_overflow),
        .issue_enable   (issue_enable)
    );

    inst_queue #(.DEPTH(`ID_QUEUE_DEPTH)) inst_queue_i (
        .clk            (clk),
        .reset          (reset),
        .push_valid     (push_valid),
        .push_data      (push_data),
        .pop            (pop),
        .clear_overflow (clear_overflow),
        .head_valid     (head_valid),
        .head_word      (head_word),
        .level          (level),
        .overflow       (overflow)
    );

    // head word decoded in the same cycle
    idu_1 idu_1_i (
        .inst   (head_word),
        .bundle (head_bundle)
    );

    dec_scoreboard dec_scoreboard_i (
        .clk          (clk),
        .reset        (reset),
        .issue_enable (issue_enable),
        .head_valid   (head_valid),
        .head_bundle  (head_bundle),
        .issue_ready  (issue_ready),
        .retire_valid (retire_valid),
        .retire_reg   (retire_reg),
        .pop          (pop),
        .issued_pulse (issued_pulse),
        .busy_any     (busy_any),
        .issue_valid  (issue_valid),
        .issue_bundle (issue_bundle)
    );

endmodule

// ==== verilog/id_ctrl_regs.sv ====
`timescale 1ns/1ns

`include "id_settings.svh"

module id_ctrl_regs
    import id_pkg::*;
#(
    parameter int LEVEL_W = 4
) (
    input  logic               clk,
    input  logic               reset,
    input  wb_req_t            wb_req,
    input  logic [LEVEL_W-1:0] level,
    input  logic               overflow,
    input  logic               busy_any,
    input  logic               issued_pulse,
    output wb_rsp_t            wb_rsp,
    output logic               push_valid,
    output logic [31:0]        push_data,
    output logic               clear_overflow,
    output logic               issue_enable
);

    localparam logic [`ID_WB_AW-1:0] ADR_PUSH   = `ID_WB_AW'(`ID_ADR_PUSH);
    localparam logic [`ID_WB_AW-1:0] ADR_CTRL   = `ID_WB_AW'(`ID_ADR_CTRL);
    localparam logic [`ID_WB_AW-1:0] ADR_STATUS = `ID_WB_AW'(`ID_ADR_STATUS);
    localparam logic [`ID_WB_AW-1:0] ADR_COUNT  = `ID_WB_AW'(`ID_ADR_COUNT);

    logic                 ack;
    logic                 wr_cycle;
    logic [31:0]          issue_count;
    logic [`ID_WB_DW-1:0] rd_data;

    // master holds the request through the ack cycle
    assign wr_cycle = ack && wb_req.cyc && wb_req.stb && wb_req.we;

    assign push_valid     = wr_cycle && (wb_req.adr == ADR_PUSH);
    assign push_data      = wb_req.dat_w[31:0];
    assign clear_overflow = wr_cycle && (wb_req.adr == ADR_CTRL)
                            && wb_req.dat_w[`ID_CTRL_CLR_OVF_BIT];

    always_ff @(posedge clk) begin
        if (reset)
            ack <= 1'b0;
        else
            ack <= wb_req.cyc && wb_req.stb && !ack;   // single pulse per strobe
    end

    always_ff @(posedge clk) begin
        if (reset)
            issue_enable <= 1'b0;
        else if (wr_cycle && wb_req.adr == ADR_CTRL)
            issue_enable <= wb_req.dat_w[`ID_CTRL_ENABLE_BIT];
    end

    always_ff @(posedge clk) begin
        if (reset)
            issue_count <= '0;
        else if (issued_pulse)
            issue_count <= issue_count + 32'd1;   // wraps
    end

    always_comb begin
        rd_data = '0;
        case (wb_req.adr)
            ADR_CTRL:
                rd_data[`ID_CTRL_ENABLE_BIT] = issue_enable;
            ADR_STATUS: begin
                rd_data[LEVEL_W-1:0]       = level;
                rd_data[`ID_STAT_OVF_BIT]  = overflow;
                rd_data[`ID_STAT_BUSY_BIT] = busy_any;
            end
            ADR_COUNT:
                rd_data = issue_count;
            default:
                rd_data = '0;    // push reads back zero
        endcase
    end

    assign wb_rsp.ack   = ack;
    assign wb_rsp.dat_r = rd_data;

endmodule

// ==== verilog/dec_scoreboard.sv ====
`timescale 1ns/1ns

module dec_scoreboard
    import id_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       issue_enable,
    input  logic       head_valid,
    input  id_bundle_t head_bundle,
    input  logic       issue_ready,
    input  logic       retire_valid,
    input  logic [4:0] retire_reg,
    output logic       pop,
    output logic       issued_pulse,
    output logic       busy_any,
    output logic       issue_valid,
    output id_bundle_t issue_bundle
);

    logic [31:1] busy;
    logic [31:0] busy_vec;
    logic [31:0] busy_next;
    logic        slot_free;
    logic        hazard;
    logic        load;

    assign busy_vec = {busy, 1'b0};   // r0 never busy

    // uses busy bits from before this cycle's retire
    assign hazard = (head_bundle.reads_rs && busy_vec[head_bundle.rs])
                    || (head_bundle.reads_rt && busy_vec[head_bundle.rt])
                    || (head_bundle.w_reg_ena && busy_vec[head_bundle.w_reg_dst]);

    assign slot_free    = !issue_valid || issue_ready;
    assign load         = issue_enable && head_valid && slot_free && !hazard;
    assign pop          = load;
    assign issued_pulse = issue_valid && issue_ready;
    assign busy_any     = |busy;

    always_comb begin
        busy_next = busy_vec;
        if (retire_valid)
            busy_next[retire_reg] = 1'b0;
        if (load && head_bundle.w_reg_ena)
            busy_next[head_bundle.w_reg_dst] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset)
            busy <= '0;
        else
            busy <= busy_next[31:1];
    end

    always_ff @(posedge clk) begin
        if (reset)
            issue_valid <= 1'b0;
        else if (load)
            issue_valid <= 1'b1;
        else if (issue_ready)
            issue_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (load)
            issue_bundle <= head_bundle;
    end

    hold_when_stalled: assert property (@(posedge clk) disable iff (reset)
        issue_valid && !issue_ready |=> issue_valid && $stable(issue_bundle))
        else $error("dec_scoreboard: issue bundle changed under back-pressure");

    retire_of_busy: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> busy_vec[retire_reg])
        else $error("dec_scoreboard: retire of register %0d that is not busy", retire_reg);

endmodule

// ==== verilog/inst_queue.sv ====
`timescale 1ns/1ns

`include "id_settings.svh"

module inst_queue #(
    parameter int DEPTH = `ID_QUEUE_DEPTH
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       push_valid,
    input  logic [31:0]                push_data,
    input  logic                       pop,
    input  logic                       clear_overflow,
    output logic                       head_valid,
    output logic [31:0]                head_word,
    output logic [$clog2(DEPTH+1)-1:0] level,
    output logic                       overflow
);

    localparam int PW = $clog2(DEPTH);

    logic [31:0]   mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic          full;
    logic          do_push;
    logic          do_pop;

    assign full       = (level == DEPTH[$clog2(DEPTH+1)-1:0]);
    assign head_valid = (level != '0);
    assign head_word  = mem[rd_ptr];
    assign do_push    = push_valid && !full;   // full queue drops the word
    assign do_pop     = pop && head_valid;

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            level    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;  // power of two depth wraps
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)
                level <= level + 1'b1;
            else if (do_pop && !do_push)
                level <= level - 1'b1;
            if (push_valid && full)
                overflow <= 1'b1;         // sticky, set beats clear
            else if (clear_overflow)
                overflow <= 1'b0;
        end
    end

    pop_not_empty: assert property (@(posedge clk) disable iff (reset) pop |-> head_valid)
        else $error("inst_queue: pop while empty");

endmodule

// ==== verilog/idu_1.sv ====
`timescale 1ns/1ns

module idu_1
    import id_pkg::*;
(
    input  logic [31:0] inst,
    output id_bundle_t  bundle
);

    op_code_e     op;
    funct_e       fn;
    logic [4:0]   rs;
    logic [4:0]   rt;
    logic [4:0]   rd;
    logic         special;
    logic         alu_rr;       // two-register alu and variable shifts
    logic         shift_imm;
    logic         muldiv;
    logic         rd_writer;
    logic         rt_writer;
    logic         link_writer;
    logic         non_writer;
    logic [4:0]   dst;
    logic         is_branch;
    logic         is_j_imme;
    logic         is_jr;
    logic         is_ls;
    logic         is_hilo;
    issue_class_e cls;

    assign op = op_code_e'(inst[31:26]);
    assign fn = funct_e'(inst[5:0]);
    assign rs = inst[25:21];
    assign rt = inst[20:16];
    assign rd = inst[15:11];

    assign special   = (op == OP_SPECIAL);
    assign alu_rr    = special && (fn inside {FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT,
                                              FN_SLTU, FN_AND, FN_OR, FN_XOR, FN_NOR,
                                              FN_SLLV, FN_SRLV, FN_SRAV});
    assign shift_imm = special && (fn inside {FN_SLL, FN_SRL, FN_SRA});
    assign muldiv    = special && (fn inside {FN_MULT, FN_MULTU, FN_DIV, FN_DIVU});

    // destination select
    assign rd_writer   = alu_rr || shift_imm || (special && (fn inside {FN_JALR, FN_MFHI,
                                                                         FN_MFLO}));
    assign rt_writer   = (op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI,
                                     OP_XORI, OP_LUI, OP_LB, OP_LH, OP_LBU, OP_LHU, OP_LW,
                                     OP_LWL, OP_LWR})
                         || (op == OP_COP0 && rs == C0_MFC0);
    assign link_writer = (op == OP_JAL) || (op == OP_REGIMM && (rt inside {RT_BLTZAL,
                                                                           RT_BGEZAL}));
    assign dst = ({5{rd_writer}} & rd) | ({5{rt_writer}} & rt) | ({5{link_writer}} & 5'd31);

    assign non_writer = muldiv
                        || (special && (fn inside {FN_JR, FN_MTHI, FN_MTLO, FN_BREAK,
                                                   FN_SYSCALL}))
                        || (op inside {OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ, OP_J, OP_SB, OP_SH,
                                       OP_SW})
                        || (op == OP_REGIMM && (rt inside {RT_BGEZ, RT_BLTZ}))
                        || (op == OP_COP0 && (rs inside {C0_MTC0, C0_ERET}));

    assign is_branch = op inside {OP_BEQ, OP_BNE, OP_REGIMM, OP_BGTZ, OP_BLEZ, OP_JAL};
    assign is_j_imme = op inside {OP_J, OP_JAL};
    assign is_jr     = special && (fn inside {FN_JR, FN_JALR});
    assign is_ls     = op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW,
                                  OP_LWL, OP_LWR};
    assign is_hilo   = muldiv || (special && (fn inside {FN_MFHI, FN_MFLO, FN_MTHI,
                                                          FN_MTLO}));

    always_comb begin
        if (is_j_imme)
            cls = CLS_JUMP;       // jal is also flagged as branch
        else if (is_jr)
            cls = CLS_JUMP_REG;
        else if (is_branch)
            cls = CLS_BRANCH;
        else if (is_ls)
            cls = CLS_LOAD_STORE;
        else if (is_hilo)
            cls = CLS_HILO;
        else if (op == OP_COP0 || (special && (fn inside {FN_SYSCALL, FN_BREAK})))
            cls = CLS_SYSTEM;
        else
            cls = CLS_ALU;
    end

    always_comb begin
        bundle.inst        = inst;
        bundle.op_code     = op;
        bundle.rs          = rs;
        bundle.rt          = rt;
        bundle.rd          = rd;
        bundle.sa          = inst[10:6];
        bundle.funct       = inst[5:0];
        bundle.imme        = inst[15:0];
        bundle.j_imme      = inst[25:0];
        bundle.w_reg_dst   = dst;
        bundle.w_reg_ena   = !non_writer && (dst != 5'd0);
        bundle.reads_rs    = alu_rr || muldiv || is_jr || is_ls
                             || (special && (fn inside {FN_MTHI, FN_MTLO}))
                             || (op inside {OP_REGIMM, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
                                            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI,
                                            OP_ORI, OP_XORI});
        bundle.reads_rt    = alu_rr || shift_imm || muldiv
                             || (op inside {OP_BEQ, OP_BNE, OP_SB, OP_SH, OP_SW, OP_LWL,
                                            OP_LWR})
                             || (op == OP_COP0 && rs == C0_MTC0);
        bundle.is_branch   = is_branch;
        bundle.is_j_imme   = is_j_imme;
        bundle.is_jr       = is_jr;
        bundle.is_ls       = is_ls;
        bundle.is_hilo     = is_hilo;
        bundle.issue_class = cls;
    end

    // flag lists and class priority must stay consistent
    always_comb begin
        assert (!(bundle.is_ls && bundle.issue_class == CLS_JUMP))
            else $error("idu_1: load/store word classified as jump");
    end

endmodule

// ==== verilog/id_pkg.sv ====
`include "id_settings.svh"

package id_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02, OP_JAL   = 6'h03,
        OP_BEQ     = 6'h04, OP_BNE    = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ  = 6'h07,
        OP_ADDI    = 6'h08, OP_ADDIU  = 6'h09, OP_SLTI  = 6'h0a, OP_SLTIU = 6'h0b,
        OP_ANDI    = 6'h0c, OP_ORI    = 6'h0d, OP_XORI  = 6'h0e, OP_LUI   = 6'h0f,
        OP_COP0    = 6'h10,
        OP_LB      = 6'h20, OP_LH     = 6'h21, OP_LWL   = 6'h22, OP_LW    = 6'h23,
        OP_LBU     = 6'h24, OP_LHU    = 6'h25, OP_LWR   = 6'h26,
        OP_SB      = 6'h28, OP_SH     = 6'h29, OP_SW    = 6'h2b
    } op_code_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00, FN_SRL   = 6'h02, FN_SRA     = 6'h03, FN_SLLV  = 6'h04,
        FN_SRLV = 6'h06, FN_SRAV  = 6'h07, FN_JR      = 6'h08, FN_JALR  = 6'h09,
        FN_SYSCALL = 6'h0c, FN_BREAK = 6'h0d,
        FN_MFHI = 6'h10, FN_MTHI  = 6'h11, FN_MFLO    = 6'h12, FN_MTLO  = 6'h13,
        FN_MULT = 6'h18, FN_MULTU = 6'h19, FN_DIV     = 6'h1a, FN_DIVU  = 6'h1b,
        FN_ADD  = 6'h20, FN_ADDU  = 6'h21, FN_SUB     = 6'h22, FN_SUBU  = 6'h23,
        FN_AND  = 6'h24, FN_OR    = 6'h25, FN_XOR     = 6'h26, FN_NOR   = 6'h27,
        FN_SLT  = 6'h2a, FN_SLTU  = 6'h2b
    } funct_e;

    typedef enum logic [4:0] {
        RT_BLTZ = 5'h00, RT_BGEZ = 5'h01, RT_BLTZAL = 5'h10, RT_BGEZAL = 5'h11
    } regimm_rt_e;

    // eret lives in the cop0 space with the CO bit set in rs (funct 0x18)
    typedef enum logic [4:0] {
        C0_MFC0 = 5'h00, C0_MTC0 = 5'h04, C0_ERET = 5'h10
    } cop0_rs_e;

    typedef enum logic [2:0] {
        CLS_ALU, CLS_BRANCH, CLS_JUMP, CLS_JUMP_REG, CLS_LOAD_STORE, CLS_HILO, CLS_SYSTEM
    } issue_class_e;

    typedef struct packed {
        logic [31:0]  inst;
        op_code_e     op_code;
        logic [4:0]   rs;
        logic [4:0]   rt;
        logic [4:0]   rd;
        logic [4:0]   sa;
        logic [5:0]   funct;      // raw bits, only meaningful for special
        logic [15:0]  imme;
        logic [25:0]  j_imme;
        logic         w_reg_ena;
        logic [4:0]   w_reg_dst;
        logic         reads_rs;
        logic         reads_rt;
        logic         is_branch;
        logic         is_j_imme;
        logic         is_jr;
        logic         is_ls;
        logic         is_hilo;
        issue_class_e issue_class;
    } id_bundle_t;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [`ID_WB_AW-1:0] adr;
        logic [`ID_WB_DW-1:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic                 ack;
        logic [`ID_WB_DW-1:0] dat_r;
    } wb_rsp_t;

endpackage

// ==== verilog/id_settings.svh ====
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// instruction queue
`define ID_QUEUE_DEPTH 8

// wishbone bus
`define ID_WB_AW 4
`define ID_WB_DW 32

// register map, byte addresses
`define ID_ADR_PUSH   0
`define ID_ADR_CTRL   4
`define ID_ADR_STATUS 8
`define ID_ADR_COUNT  12

// ctrl register bits
`define ID_CTRL_ENABLE_BIT 0
`define ID_CTRL_CLR_OVF_BIT 1

// status register bits
`define ID_STAT_OVF_BIT  8
`define ID_STAT_BUSY_BIT 9

`endif
